/* compile.f */
logic/isaPkg.sv
logic/controlPkg.sv
logic/sequencerBus.sv
logic/instrDecoder.sv
logic/mainSequencer.sv
logic/signalEncoder.sv
logic/controlUnit.sv
test/controlUnitAsserts.sv
test/controlChecker.sv
test/controlUnitTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= controlUnitTb
BUILD     ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert

SOURCES := $(wildcard logic/*.sv) $(wildcard test/*.sv)
BIN     := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "all tests passed" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

/* test/controlUnitTb.sv */
`timescale 1ns/10ps
`default_nettype none

module controlUnitTb;

    localparam int MultDivCycles = 4;
    localparam int TimeoutCycles = 40;
    localparam int RowCount = 22;

    typedef struct packed {
        logic [5:0] opcode;
        logic [5:0] funct;
        logic       div0;
        logic       overflow;
        logic       eq;
        logic       gt;
        logic       lt;
        logic       randomFlags;
    } rowT;

    rowT stimulus [RowCount];
    logic clk;
    logic reset;
    logic [5:0] opcode;
    logic [5:0] funct;
    logic div0;
    logic overflow;
    logic eq;
    logic gt;
    logic lt;
    logic pcWrite;
    logic iOrD;
    logic memRead;
    logic irWrite;
    logic [2:0] memToReg;
    logic regWrite;
    logic regDst;
    logic multOrDiv;
    logic hiWrite;
    logic loWrite;
    logic aluOutWrite;
    logic [1:0] pcSource;
    logic [2:0] aluOp;
    logic [1:0] aluSrcA;
    logic [2:0] aluSrcB;
    logic writeA;
    logic writeB;
    logic epcWrite;
    logic [1:0] exceptionCause;
    logic [15:0] lfsr;
    bit timedOut;
    int errorCount;
    int checkCount;

    controlUnit #(.MultDivCycles(MultDivCycles)) UUT (
        .clk(clk), .reset(reset), .opcode(opcode), .funct(funct),
        .div0(div0), .overflow(overflow), .eq(eq), .gt(gt), .lt(lt),
        .pcWrite(pcWrite), .iOrD(iOrD), .memRead(memRead), .irWrite(irWrite),
        .memToReg(memToReg), .regWrite(regWrite), .regDst(regDst),
        .multOrDiv(multOrDiv), .hiWrite(hiWrite), .loWrite(loWrite),
        .aluOutWrite(aluOutWrite), .pcSource(pcSource), .aluOp(aluOp),
        .aluSrcA(aluSrcA), .aluSrcB(aluSrcB), .writeA(writeA), .writeB(writeB),
        .epcWrite(epcWrite), .exceptionCause(exceptionCause)
    );

    controlChecker #(.MultDivCycles(MultDivCycles)) monitor (
        .clk(clk), .reset(reset), .opcode(opcode), .funct(funct),
        .div0(div0), .overflow(overflow), .eq(eq), .gt(gt),
        .pcWrite(pcWrite), .iOrD(iOrD), .memRead(memRead), .irWrite(irWrite),
        .memToReg(memToReg), .regWrite(regWrite), .regDst(regDst),
        .multOrDiv(multOrDiv), .hiWrite(hiWrite), .loWrite(loWrite),
        .aluOutWrite(aluOutWrite), .pcSource(pcSource), .aluOp(aluOp),
        .aluSrcA(aluSrcA), .aluSrcB(aluSrcB), .writeA(writeA), .writeB(writeB),
        .epcWrite(epcWrite), .exceptionCause(exceptionCause),
        .errorCount(errorCount), .checkCount(checkCount)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrNext(input logic [15:0] value);
        if (value[0]) begin
            return (value >> 1) ^ 16'hB400;
        end
        return value >> 1;
    endfunction

    task automatic drawBit(output logic b);
        b = lfsr[0];
        lfsr = lfsrNext(lfsr);
    endtask

    function automatic rowT makeRow(input logic [5:0] op, input logic [5:0] fn,
                                    input logic [5:0] flags);
        rowT r;
        r.opcode = op;
        r.funct = fn;
        {r.div0, r.overflow, r.eq, r.gt, r.lt, r.randomFlags} = flags;
        return r;
    endfunction

    task automatic fillStimulus();
        // Flags column: div0 overflow eq gt lt randomFlags
        stimulus[0] = makeRow(6'h00, 6'h10, 6'b000000);
        stimulus[1] = makeRow(6'h00, 6'h12, 6'b000000);
        stimulus[2] = makeRow(6'h00, 6'h08, 6'b000000);
        stimulus[3] = makeRow(6'h02, 6'h00, 6'b000000);
        stimulus[4] = makeRow(6'h04, 6'h00, 6'b000001);
        stimulus[5] = makeRow(6'h05, 6'h00, 6'b000001);
        stimulus[6] = makeRow(6'h07, 6'h00, 6'b000001);
        stimulus[7] = makeRow(6'h06, 6'h00, 6'b000001);
        stimulus[8] = makeRow(6'h04, 6'h00, 6'b000001);
        stimulus[9] = makeRow(6'h07, 6'h00, 6'b000001);
        stimulus[10] = makeRow(6'h06, 6'h00, 6'b000001);
        stimulus[11] = makeRow(6'h05, 6'h00, 6'b000001);
        stimulus[12] = makeRow(6'h00, 6'h18, 6'b000000);
        stimulus[13] = makeRow(6'h00, 6'h1A, 6'b000000);
        stimulus[14] = makeRow(6'h00, 6'h18, 6'b010000);
        stimulus[15] = makeRow(6'h00, 6'h1A, 6'b100000);
        // Flag of the other unit must not fault
        stimulus[16] = makeRow(6'h00, 6'h18, 6'b100000);
        stimulus[17] = makeRow(6'h00, 6'h1A, 6'b010000);
        stimulus[18] = makeRow(6'h3F, 6'h00, 6'b000000);
        stimulus[19] = makeRow(6'h00, 6'h20, 6'b000000);
        // Not taken beq and bgt
        stimulus[20] = makeRow(6'h04, 6'h00, 6'b000100);
        stimulus[21] = makeRow(6'h07, 6'h00, 6'b001000);
    endtask

    task automatic applyRow(input rowT r);
        opcode = r.opcode;
        funct = r.funct;
        div0 = r.div0;
        overflow = r.overflow;
        eq = r.eq;
        gt = r.gt;
        lt = r.lt;
        if (r.randomFlags) begin
            drawBit(eq);
            drawBit(gt);
            drawBit(lt);
        end
    endtask

    // Returns on the falling edge inside the next fetch cycle
    task automatic waitForFetch();
        int n;
        n = 0;
        @(negedge clk);
        while (!irWrite && n < TimeoutCycles) begin
            @(negedge clk);
            n++;
        end
        if (!irWrite) begin
            timedOut = 1'b1;
            $display("Timeout: no instruction fetch seen within %0d cycles", TimeoutCycles);
        end
    endtask

    initial begin
        lfsr = 16'd6621;
        timedOut = 1'b0;
        reset = 1'b1;
        applyRow(makeRow(6'h02, 6'h00, 6'b000000));
        fillStimulus();
        repeat (5) @(negedge clk);
        reset = 1'b0;
        waitForFetch();
        for (int i = 0; i < RowCount && !timedOut; i++) begin
            applyRow(stimulus[i]);
            waitForFetch();
        end
        if (!timedOut) begin
            // Let the checker close the last instruction
            @(posedge clk);
            #1;
        end
        $display("Checks %0d, errors %0d, timeouts %0d", checkCount, errorCount,
                 timedOut ? 1 : 0);
        if (errorCount == 0 && !timedOut) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/controlChecker.sv */
`timescale 1ns/10ps
`default_nettype none

module controlChecker #(
    parameter int MultDivCycles = 4
) (
    input  logic       clk,
    input  logic       reset,
    input  logic [5:0] opcode,
    input  logic [5:0] funct,
    input  logic       div0,
    input  logic       overflow,
    input  logic       eq,
    input  logic       gt,
    input  logic       pcWrite,
    input  logic       iOrD,
    input  logic       memRead,
    input  logic       irWrite,
    input  logic [2:0] memToReg,
    input  logic       regWrite,
    input  logic       regDst,
    input  logic       multOrDiv,
    input  logic       hiWrite,
    input  logic       loWrite,
    input  logic       aluOutWrite,
    input  logic [1:0] pcSource,
    input  logic [2:0] aluOp,
    input  logic [1:0] aluSrcA,
    input  logic [2:0] aluSrcB,
    input  logic       writeA,
    input  logic       writeB,
    input  logic       epcWrite,
    input  logic [1:0] exceptionCause,
    output int         errorCount,
    output int         checkCount
);

    localparam int ClsMult = 0;
    localparam int ClsDiv = 1;
    localparam int ClsMfhi = 2;
    localparam int ClsMflo = 3;
    localparam int ClsJr = 4;
    localparam int ClsJump = 5;
    localparam int ClsBranch = 6;
    localparam int ClsIllegal = 7;

    int   step;
    int   cyclesSeen;
    int   pendingLen;
    int   curClass;
    bit   started;
    logic fault;
    logic ePcWrite;
    logic eMemRead;
    logic eIrWrite;
    logic eRegWrite;
    logic eRegDst;
    logic eMultOrDiv;
    logic eHiWrite;
    logic eLoWrite;
    logic eAluOutWrite;
    logic eWriteA;
    logic eWriteB;
    logic eEpcWrite;
    logic [2:0] eMemToReg;
    logic [1:0] ePcSource;
    logic [2:0] eAluOp;
    logic [1:0] eAluSrcA;
    logic [2:0] eAluSrcB;
    logic [1:0] eCause;

    initial begin
        errorCount = 0;
        checkCount = 0;
        started = 1'b0;
        cyclesSeen = 0;
        pendingLen = 0;
        curClass = ClsIllegal;
        step = 0;
    end

    // Instruction class straight from the MIPS field values
    function automatic int classify(input logic [5:0] op, input logic [5:0] fn);
        case (op)
            6'h00: begin
                case (fn)
                    6'h18: return ClsMult;
                    6'h1A: return ClsDiv;
                    6'h10: return ClsMfhi;
                    6'h12: return ClsMflo;
                    6'h08: return ClsJr;
                    default: return ClsIllegal;
                endcase
            end
            6'h02: return ClsJump;
            6'h04, 6'h05, 6'h06, 6'h07: return ClsBranch;
            default: return ClsIllegal;
        endcase
    endfunction

    function automatic logic branchRule(input logic [5:0] op, input logic e, input logic g);
        case (op)
            6'h04: return e;
            6'h05: return !e;
            6'h07: return g;
            default: return !g;
        endcase
    endfunction

    function automatic int lengthOf(input int cls);
        if (cls == ClsMult || cls == ClsDiv) begin
            return 3 + MultDivCycles;
        end
        return 3;
    endfunction

    task automatic compare(input string name, input logic [3:0] expected,
                           input logic [3:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("FAILED at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    task automatic exceptionStep(input logic [1:0] cause);
        eEpcWrite = 1'b1;
        ePcWrite = 1'b1;
        ePcSource = controlPkg::pcRegister;
        eCause = cause;
    endtask

    task automatic predict(input int s);
        ePcWrite = 1'b0;
        eMemRead = 1'b0;
        eIrWrite = 1'b0;
        eRegWrite = 1'b0;
        eRegDst = 1'b0;
        eMultOrDiv = 1'b0;
        eHiWrite = 1'b0;
        eLoWrite = 1'b0;
        eAluOutWrite = 1'b0;
        eWriteA = 1'b0;
        eWriteB = 1'b0;
        eEpcWrite = 1'b0;
        eMemToReg = controlPkg::regFromAlu;
        ePcSource = controlPkg::pcPlus4;
        eAluOp = controlPkg::aluAdd;
        eAluSrcA = controlPkg::srcPc;
        eAluSrcB = controlPkg::srcRegB;
        eCause = isaPkg::causeOpcode;
        fault = (curClass == ClsMult && overflow) || (curClass == ClsDiv && div0);
        if (s <= 0) begin
            // Fetch selects, also held while in reset
            eAluSrcB = controlPkg::srcFour;
            if (s == 0) begin
                eMemRead = 1'b1;
                eIrWrite = 1'b1;
                ePcWrite = 1'b1;
            end
        end else if (s == 1) begin
            eWriteA = 1'b1;
            eWriteB = 1'b1;
            eAluOutWrite = 1'b1;
            eAluSrcB = controlPkg::srcImmShifted;
        end else begin
            case (curClass)
                ClsMfhi: begin
                    eRegWrite = 1'b1;
                    eRegDst = 1'b1;
                    eMemToReg = controlPkg::regFromHi;
                end
                ClsMflo: begin
                    eRegWrite = 1'b1;
                    eRegDst = 1'b1;
                    eMemToReg = controlPkg::regFromLo;
                end
                ClsJr: begin
                    ePcWrite = 1'b1;
                    ePcSource = controlPkg::pcRegister;
                    eAluSrcA = controlPkg::srcRegA;
                end
                ClsJump: begin
                    ePcWrite = 1'b1;
                    ePcSource = controlPkg::pcJumpTarget;
                end
                ClsBranch: begin
                    // A and B compared in the ALU
                    eAluSrcA = controlPkg::srcRegA;
                    eAluOp = controlPkg::aluCompare;
                    ePcSource = controlPkg::pcBranchTarget;
                    ePcWrite = branchRule(opcode, eq, gt);
                end
                ClsIllegal: exceptionStep(isaPkg::causeOpcode);
                default: begin
                    eMultOrDiv = (s == 2);
                    if (s == MultDivCycles + 2) begin
                        if (!fault) begin
                            eHiWrite = 1'b1;
                            eLoWrite = 1'b1;
                        end else if (curClass == ClsMult) begin
                            exceptionStep(isaPkg::causeOverflow);
                        end else begin
                            exceptionStep(isaPkg::causeDivZero);
                        end
                    end
                end
            endcase
        end
    endtask

    task automatic compareAll();
        compare("pcWrite", {3'b0, ePcWrite}, {3'b0, pcWrite});
        compare("iOrD", 4'b0, {3'b0, iOrD});
        compare("memRead", {3'b0, eMemRead}, {3'b0, memRead});
        compare("irWrite", {3'b0, eIrWrite}, {3'b0, irWrite});
        compare("regWrite", {3'b0, eRegWrite}, {3'b0, regWrite});
        compare("regDst", {3'b0, eRegDst}, {3'b0, regDst});
        compare("memToReg", {1'b0, eMemToReg}, {1'b0, memToReg});
        compare("multOrDiv", {3'b0, eMultOrDiv}, {3'b0, multOrDiv});
        compare("hiWrite", {3'b0, eHiWrite}, {3'b0, hiWrite});
        compare("loWrite", {3'b0, eLoWrite}, {3'b0, loWrite});
        compare("aluOutWrite", {3'b0, eAluOutWrite}, {3'b0, aluOutWrite});
        compare("writeA", {3'b0, eWriteA}, {3'b0, writeA});
        compare("writeB", {3'b0, eWriteB}, {3'b0, writeB});
        compare("epcWrite", {3'b0, eEpcWrite}, {3'b0, epcWrite});
        compare("pcSource", {2'b0, ePcSource}, {2'b0, pcSource});
        compare("aluOp", {1'b0, eAluOp}, {1'b0, aluOp});
        compare("aluSrcA", {2'b0, eAluSrcA}, {2'b0, aluSrcA});
        compare("aluSrcB", {1'b0, eAluSrcB}, {1'b0, aluSrcB});
        compare("exceptionCause", {2'b0, eCause}, {2'b0, exceptionCause});
    endtask

    // Sampled before the edge updates the state
    always @(posedge clk) begin
        if (reset) begin
            started = 1'b0;
            predict(-1);
            compareAll();
        end else begin
            if (irWrite) begin
                if (started && cyclesSeen != pendingLen) begin
                    errorCount++;
                    $display("FAILED at %0t: instruction length expected %0d, got %0d",
                             $time, pendingLen, cyclesSeen);
                end
                curClass = classify(opcode, funct);
                pendingLen = lengthOf(curClass);
                step = 0;
                cyclesSeen = 1;
                started = 1'b1;
            end else if (started) begin
                step = cyclesSeen;
                cyclesSeen++;
            end
            if (started) begin
                predict(step);
                compareAll();
            end
        end
    end

endmodule

`default_nettype wire

/* test/controlUnitAsserts.sv */
`timescale 1ns/10ps
`default_nettype none

module controlUnitAsserts (
    input logic                 clk,
    input logic                 reset,
    input controlPkg::stateT    state,
    input logic                 multDivStart,
    input logic                 lastCycle,
    input logic                 fault
);

    logic inException;

    assign inException = (state == controlPkg::sException);

    multDivPulse: assert property (@(posedge clk) disable iff (reset)
        multDivStart |=> !multDivStart)
        else $error("multOrDiv held longer than one cycle");

    epcPulse: assert property (@(posedge clk) disable iff (reset)
        inException |=> !inException)
        else $error("epcWrite held longer than one cycle");

    // A faulting mult/div goes to the exception step, never to the hi/lo write
    hiVersusEpc: assert property (@(posedge clk) disable iff (reset)
        (lastCycle && fault) |=> inException)
        else $error("faulting mult/div did not enter the exception step");

    resetState: assert property (@(posedge clk) reset |-> state == controlPkg::sFetch)
        else $error("state left fetch while reset held");

endmodule

bind mainSequencer controlUnitAsserts protocolChecks (
    .clk          (clk),
    .reset        (reset),
    .state        (state),
    .multDivStart (bus.multDivStart),
    .lastCycle    (lastCycle),
    .fault        (fault)
);

`default_nettype wire

/* logic/controlUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module controlUnit #(
    parameter int MultDivCycles = 4
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [isaPkg::OpcodeWidth-1:0]     opcode,
    input  logic [isaPkg::FunctWidth-1:0]      funct,
    input  logic                               div0,
    input  logic                               overflow,
    input  logic                               eq,
    input  logic                               gt,
    input  logic                               lt,
    output logic                               pcWrite,
    output logic                               iOrD,
    output logic                               memRead,
    output logic                               irWrite,
    output controlPkg::memToRegT               memToReg,
    output logic                               regWrite,
    output logic                               regDst,
    output logic                               multOrDiv,
    output logic                               hiWrite,
    output logic                               loWrite,
    output logic                               aluOutWrite,
    output controlPkg::pcSourceT               pcSource,
    output controlPkg::aluOpT                  aluOp,
    output controlPkg::aluSrcAT                aluSrcA,
    output controlPkg::aluSrcBT                aluSrcB,
    output logic                               writeA,
    output logic                               writeB,
    output logic                               epcWrite,
    output isaPkg::causeT                      exceptionCause
);

    controlPkg::instrClassT instrClass;

    sequencerBus stepBus ();

    // Raw instruction fields may hold codes outside the enums
    instrDecoder decoder (
        .opcode     (isaPkg::opcodeT'(opcode)),
        .funct      (isaPkg::functT'(funct)),
        .instrClass (instrClass)
    );

    mainSequencer #(
        .MultDivCycles (MultDivCycles)
    ) sequencer (
        .clk        (clk),
        .reset      (reset),
        .instrClass (instrClass),
        .div0       (div0),
        .overflow   (overflow),
        .eq         (eq),
        .gt         (gt),
        .lt         (lt),
        .bus        (stepBus.sequencer)
    );

    signalEncoder encoder (
        .bus            (stepBus.encoder),
        .pcWrite        (pcWrite),
        .iOrD           (iOrD),
        .memRead        (memRead),
        .irWrite        (irWrite),
        .memToReg       (memToReg),
        .regWrite       (regWrite),
        .regDst         (regDst),
        .multOrDiv      (multOrDiv),
        .hiWrite        (hiWrite),
        .loWrite        (loWrite),
        .aluOutWrite    (aluOutWrite),
        .pcSource       (pcSource),
        .aluOp          (aluOp),
        .aluSrcA        (aluSrcA),
        .aluSrcB        (aluSrcB),
        .writeA         (writeA),
        .writeB         (writeB),
        .epcWrite       (epcWrite),
        .exceptionCause (exceptionCause)
    );

endmodule

`default_nettype wire

/* logic/signalEncoder.sv */
`timescale 1ns/10ps
`default_nettype none

module signalEncoder (
    sequencerBus.encoder           bus,
    output logic                   pcWrite,
    output logic                   iOrD,
    output logic                   memRead,
    output logic                   irWrite,
    output controlPkg::memToRegT   memToReg,
    output logic                   regWrite,
    output logic                   regDst,
    output logic                   multOrDiv,
    output logic                   hiWrite,
    output logic                   loWrite,
    output logic                   aluOutWrite,
    output controlPkg::pcSourceT   pcSource,
    output controlPkg::aluOpT      aluOp,
    output controlPkg::aluSrcAT    aluSrcA,
    output controlPkg::aluSrcBT    aluSrcB,
    output logic                   writeA,
    output logic                   writeB,
    output logic                   epcWrite,
    output isaPkg::causeT          exceptionCause
);

    always_comb begin
        // Everything idle unless the step below says otherwise
        pcWrite = 1'b0;
        iOrD = 1'b0;
        memRead = 1'b0;
        irWrite = 1'b0;
        memToReg = controlPkg::regFromAlu;
        regWrite = 1'b0;
        regDst = 1'b0;
        multOrDiv = 1'b0;
        hiWrite = 1'b0;
        loWrite = 1'b0;
        aluOutWrite = 1'b0;
        pcSource = controlPkg::pcPlus4;
        aluOp = controlPkg::aluAdd;
        aluSrcA = controlPkg::srcPc;
        aluSrcB = controlPkg::srcRegB;
        writeA = 1'b0;
        writeB = 1'b0;
        epcWrite = 1'b0;
        exceptionCause = isaPkg::causeOpcode;

        case (bus.state)
            controlPkg::sFetch: begin
                // Instruction read and pc + 4
                memRead = bus.running;
                irWrite = bus.running;
                pcWrite = bus.running;
                aluSrcB = controlPkg::srcFour;
            end
            controlPkg::sDecode: begin
                writeA = 1'b1;
                writeB = 1'b1;
                // Branch target into ALUOut ahead of time
                aluOutWrite = 1'b1;
                aluSrcB = controlPkg::srcImmShifted;
            end
            controlPkg::sMultDiv: begin
                multOrDiv = bus.multDivStart;
            end
            controlPkg::sHiLoWrite: begin
                hiWrite = 1'b1;
                loWrite = 1'b1;
            end
            controlPkg::sMoveHi: begin
                regWrite = 1'b1;
                regDst = 1'b1;
                memToReg = controlPkg::regFromHi;
            end
            controlPkg::sMoveLo: begin
                regWrite = 1'b1;
                regDst = 1'b1;
                memToReg = controlPkg::regFromLo;
            end
            controlPkg::sJumpReg: begin
                pcWrite = 1'b1;
                pcSource = controlPkg::pcRegister;
                aluSrcA = controlPkg::srcRegA;
            end
            controlPkg::sJump: begin
                pcWrite = 1'b1;
                pcSource = controlPkg::pcJumpTarget;
            end
            controlPkg::sBranch: begin
                // ALU compares A and B, flags come back as eq/gt/lt
                aluSrcA = controlPkg::srcRegA;
                aluOp = controlPkg::aluCompare;
                pcSource = controlPkg::pcBranchTarget;
                pcWrite = bus.branchTaken;
            end
            controlPkg::sException: begin
                epcWrite = 1'b1;
                exceptionCause = bus.cause;
                pcWrite = 1'b1;
                pcSource = controlPkg::pcRegister;
            end
            default: begin
                pcWrite = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/mainSequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module mainSequencer #(
    parameter int MultDivCycles = 4
) (
    input  logic                   clk,
    input  logic                   reset,
    input  controlPkg::instrClassT instrClass,
    input  logic                   div0,
    input  logic                   overflow,
    input  logic                   eq,
    input  logic                   gt,
    input  logic                   lt,
    sequencerBus.sequencer         bus
);

    localparam int CountWidth = controlPkg::CycleCountWidth;
    localparam logic [CountWidth-1:0] LastCount = CountWidth'(MultDivCycles - 1);

    controlPkg::stateT      state;
    controlPkg::stateT      nextState;
    controlPkg::instrClassT currentClass;
    isaPkg::causeT          causeReg;
    logic [CountWidth-1:0]  count;
    logic                   running;
    logic                   lastCycle;
    logic                   fault;
    logic                   branchHolds;

    assign lastCycle = (state == controlPkg::sMultDiv) && (count == LastCount);

    // Overflow only matters for mult, div0 only for div
    assign fault = ((currentClass == controlPkg::clsMult) && overflow) ||
                   ((currentClass == controlPkg::clsDiv) && div0);

    // lt is not needed, ble is the complement of bgt
    always_comb begin
        branchHolds = 1'b0;
        case (currentClass)
            controlPkg::clsBeq: branchHolds = eq;
            controlPkg::clsBne: branchHolds = !eq;
            controlPkg::clsBgt: branchHolds = gt;
            controlPkg::clsBle: branchHolds = !gt;
            default:            branchHolds = 1'b0;
        endcase
    end

    always_comb begin
        nextState = controlPkg::sFetch;
        case (state)
            controlPkg::sFetch: begin
                // Hold fetch until the first edge after reset release
                nextState = running ? controlPkg::sDecode : controlPkg::sFetch;
            end
            controlPkg::sDecode: begin
                case (instrClass)
                    controlPkg::clsMult, controlPkg::clsDiv: nextState = controlPkg::sMultDiv;
                    controlPkg::clsMfhi: nextState = controlPkg::sMoveHi;
                    controlPkg::clsMflo: nextState = controlPkg::sMoveLo;
                    controlPkg::clsJr:   nextState = controlPkg::sJumpReg;
                    controlPkg::clsJump: nextState = controlPkg::sJump;
                    controlPkg::clsBeq, controlPkg::clsBne,
                    controlPkg::clsBgt, controlPkg::clsBle: nextState = controlPkg::sBranch;
                    default: nextState = controlPkg::sException;
                endcase
            end
            controlPkg::sMultDiv: begin
                if (!lastCycle) begin
                    nextState = controlPkg::sMultDiv;
                end else if (fault) begin
                    nextState = controlPkg::sException;
                end else begin
                    nextState = controlPkg::sHiLoWrite;
                end
            end
            default: nextState = controlPkg::sFetch;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= controlPkg::sFetch;
            running <= 1'b0;
            count <= '0;
            currentClass <= controlPkg::clsIllegal;
            causeReg <= isaPkg::causeOpcode;
        end else begin
            state <= nextState;
            running <= 1'b1;
            if (state == controlPkg::sMultDiv && !lastCycle) begin
                count <= count + 1'b1;
            end else begin
                count <= '0;
            end
            if (state == controlPkg::sDecode) begin
                currentClass <= instrClass;
                if (nextState == controlPkg::sException) begin
                    causeReg <= isaPkg::causeOpcode;
                end
            end
            // Fault cause is latched at the end of the last mult/div cycle
            if (lastCycle && fault) begin
                if (currentClass == controlPkg::clsMult) begin
                    causeReg <= isaPkg::causeOverflow;
                end else begin
                    causeReg <= isaPkg::causeDivZero;
                end
            end
        end
    end

    assign bus.state = state;
    assign bus.running = running;
    assign bus.multDivStart = (state == controlPkg::sMultDiv) && (count == '0);
    assign bus.branchTaken = (state == controlPkg::sBranch) && branchHolds;
    assign bus.cause = causeReg;

endmodule

`default_nettype wire

/* logic/instrDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

module instrDecoder (
    input  isaPkg::opcodeT          opcode,
    input  isaPkg::functT           funct,
    output controlPkg::instrClassT  instrClass
);

    always_comb begin
        instrClass = controlPkg::clsIllegal;
        case (opcode)
            isaPkg::rType: begin
                case (funct)
                    isaPkg::mult: instrClass = controlPkg::clsMult;
                    isaPkg::div:  instrClass = controlPkg::clsDiv;
                    isaPkg::mfhi: instrClass = controlPkg::clsMfhi;
                    isaPkg::mflo: instrClass = controlPkg::clsMflo;
                    isaPkg::jr:   instrClass = controlPkg::clsJr;
                    // Unknown function codes count as illegal too
                    default:      instrClass = controlPkg::clsIllegal;
                endcase
            end
            isaPkg::jump: instrClass = controlPkg::clsJump;
            isaPkg::beq:  instrClass = controlPkg::clsBeq;
            isaPkg::bne:  instrClass = controlPkg::clsBne;
            isaPkg::bgt:  instrClass = controlPkg::clsBgt;
            isaPkg::ble:  instrClass = controlPkg::clsBle;
            default:      instrClass = controlPkg::clsIllegal;
        endcase
    end

endmodule

`default_nettype wire

/* logic/sequencerBus.sv */
`timescale 1ns/10ps
`default_nettype none

interface sequencerBus;

    controlPkg::stateT state;
    // Low until the first clock edge after reset is released
    logic running;
    logic multDivStart;
    logic branchTaken;
    isaPkg::causeT cause;

    modport sequencer (
        output state,
        output running,
        output multDivStart,
        output branchTaken,
        output cause
    );

    modport encoder (
        input state,
        input running,
        input multDivStart,
        input branchTaken,
        input cause
    );

endinterface

`default_nettype wire

/* logic/controlPkg.sv */
`default_nettype none

package controlPkg;

    localparam int CycleCountWidth = 4;

    typedef enum logic [3:0] {
        sFetch,
        sDecode,
        sMultDiv,
        sHiLoWrite,
        sMoveHi,
        sMoveLo,
        sJumpReg,
        sJump,
        sBranch,
        sException
    } stateT;

    typedef enum logic [3:0] {
        clsMult,
        clsDiv,
        clsMfhi,
        clsMflo,
        clsJr,
        clsJump,
        clsBeq,
        clsBne,
        clsBgt,
        clsBle,
        clsIllegal
    } instrClassT;

    typedef enum logic [1:0] {
        pcPlus4        = 2'b00,
        pcBranchTarget = 2'b01,
        pcJumpTarget   = 2'b10,
        pcRegister     = 2'b11
    } pcSourceT;

    // Register file write data mux, loads are not handled
    typedef enum logic [2:0] {
        regFromAlu = 3'b000,
        regFromHi  = 3'b010,
        regFromLo  = 3'b011
    } memToRegT;

    typedef enum logic [1:0] {
        srcPc   = 2'b00,
        srcRegA = 2'b01
    } aluSrcAT;

    typedef enum logic [2:0] {
        srcRegB       = 3'b000,
        srcFour       = 3'b001,
        srcImmShifted = 3'b011
    } aluSrcBT;

    typedef enum logic [2:0] {
        aluAdd     = 3'b000,
        aluCompare = 3'b111
    } aluOpT;

endpackage

`default_nettype wire

/* logic/isaPkg.sv */
`default_nettype none

package isaPkg;

    localparam int OpcodeWidth = 6;
    localparam int FunctWidth = 6;

    // Primary opcodes handled by the control unit
    typedef enum logic [OpcodeWidth-1:0] {
        rType = 6'h00,
        jump  = 6'h02,
        beq   = 6'h04,
        bne   = 6'h05,
        ble   = 6'h06,
        bgt   = 6'h07
    } opcodeT;

    // Function field, only meaningful under rType
    typedef enum logic [FunctWidth-1:0] {
        jr   = 6'h08,
        mfhi = 6'h10,
        mflo = 6'h12,
        mult = 6'h18,
        div  = 6'h1A
    } functT;

    // Cause code, also picks the exception vector in the datapath
    typedef enum logic [1:0] {
        causeOpcode   = 2'd0,
        causeOverflow = 2'd1,
        causeDivZero  = 2'd2
    } causeT;

endpackage

`default_nettype wire
